// File: bench/dbg_mon_tb.sv
// ---------------------------------------------------------------------------
// Debug-entry monitor testbench: random and directed retirements checked
// against a rule-based reference through concurrent assertions
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dbg_mon_tb;

  localparam int n_cause   = 40;
  localparam int n_dpc     = 30;
  localparam int n_brk     = 20;
  localparam int n_wfi     = 9;
  localparam int n_dret    = 10;
  localparam int n_reset   = 2;
  localparam int total_len = n_cause + n_dpc + n_brk + n_wfi + n_dret + n_reset;

  logic                    cov_assert_if;
  logic                    rst_n;
  logic                    wb_valid;
  dbg_mon_pkg::word_t      wb_instr;
  dbg_mon_pkg::word_t      wb_pc;
  logic                    debug_mode;
  logic                    debug_req;
  logic                    trigger_match;
  logic                    ebreakm;
  logic                    step_en;
  logic                    irq_pending;
  dbg_mon_pkg::dbg_cause_e cause;
  dbg_mon_pkg::word_t      dpc;
  dbg_mon_pkg::word_t      ebreak_pc;
  logic                    wfi_sleep;
  logic                    illegal_dret;

  integer seed;
  int     err_count;
  int     fail_tests;
  int     test_count;

  // Reference model state, two edges behind the write-back inputs
  logic               m_valid;
  dbg_mon_pkg::word_t m_instr;
  dbg_mon_pkg::word_t m_pc;
  logic [2:0]         exp_cause;
  dbg_mon_pkg::word_t exp_dpc;
  dbg_mon_pkg::word_t exp_ebreak_pc;
  logic               exp_sleep;
  logic               exp_dret;

  dbg_mon_top i_dut (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n),
    .wb_valid_i      (wb_valid),
    .wb_instr_i      (wb_instr),
    .wb_pc_i         (wb_pc),
    .debug_mode_i    (debug_mode),
    .debug_req_i     (debug_req),
    .trigger_match_i (trigger_match),
    .ebreakm_i       (ebreakm),
    .step_en_i       (step_en),
    .irq_pending_i   (irq_pending),
    .cause_o         (cause),
    .dpc_o           (dpc),
    .ebreak_pc_o     (ebreak_pc),
    .wfi_sleep_o     (wfi_sleep),
    .illegal_dret_o  (illegal_dret)
  );

  always #5 cov_assert_if = ~cov_assert_if;

  // -------------------------------------------------------------------------
  // Reference rules
  // -------------------------------------------------------------------------
  function automatic logic is_brk(input dbg_mon_pkg::word_t instr);
    return (instr == dbg_mon_pkg::ebreak_insn) ||
           (instr[15:0] == dbg_mon_pkg::cebreak_insn[15:0]);
  endfunction

  // Trigger over ebreak over halt request over single step
  function automatic logic [2:0] priority_cause(input logic trig, brk, ebm, req, step);
    if (trig) return 3'd2;
    if (brk && ebm) return 3'd1;
    if (req) return 3'd3;
    if (step) return 3'd4;
    return 3'd0;
  endfunction

  always @(posedge cov_assert_if or negedge rst_n) begin
    if (!rst_n) begin
      m_valid       <= 1'b0;
      m_instr       <= '0;
      m_pc          <= '0;
      exp_cause     <= 3'd0;
      exp_dpc       <= '0;
      exp_ebreak_pc <= '0;
      exp_sleep     <= 1'b0;
      exp_dret      <= 1'b0;
    end else begin
      m_valid <= wb_valid;
      m_instr <= wb_instr;
      m_pc    <= wb_pc;
      if (m_valid && !debug_mode) begin
        exp_cause <= priority_cause(trigger_match, is_brk(m_instr), ebreakm, debug_req, step_en);
        if (trigger_match || (is_brk(m_instr) && ebreakm)) begin
          exp_dpc <= m_pc;
        end else begin
          exp_dpc <= m_pc + ((m_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
        end
      end
      if (m_valid && is_brk(m_instr)) begin
        exp_ebreak_pc <= m_pc;
      end
      if (irq_pending || debug_req) begin
        exp_sleep <= 1'b0;
      end else if (m_valid && (m_instr == dbg_mon_pkg::wfi_insn) && !debug_mode && !step_en) begin
        exp_sleep <= 1'b1;
      end
      exp_dret <= m_valid && (m_instr == dbg_mon_pkg::dret_insn) && !debug_mode;
    end
  end

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input dbg_mon_pkg::word_t got,
                                 input dbg_mon_pkg::word_t exp);
    $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    err_count++;
  endtask

  a_cause: assert property (@(posedge cov_assert_if) disable iff (!rst_n) cause == exp_cause)
    else report_mismatch("cause_o", 32'($sampled(cause)), 32'($sampled(exp_cause)));
  a_dpc: assert property (@(posedge cov_assert_if) disable iff (!rst_n) dpc == exp_dpc)
    else report_mismatch("dpc_o", $sampled(dpc), $sampled(exp_dpc));
  a_ebreak_pc: assert property (@(posedge cov_assert_if) disable iff (!rst_n)
                                ebreak_pc == exp_ebreak_pc)
    else report_mismatch("ebreak_pc_o", $sampled(ebreak_pc), $sampled(exp_ebreak_pc));
  a_sleep: assert property (@(posedge cov_assert_if) disable iff (!rst_n) wfi_sleep == exp_sleep)
    else report_mismatch("wfi_sleep_o", 32'($sampled(wfi_sleep)), 32'($sampled(exp_sleep)));
  a_dret: assert property (@(posedge cov_assert_if) disable iff (!rst_n) illegal_dret == exp_dret)
    else report_mismatch("illegal_dret_o", 32'($sampled(illegal_dret)), 32'($sampled(exp_dret)));

  // All outputs sit at zero while reset is held
  a_reset: assert property (@(posedge cov_assert_if) !rst_n |->
                            (cause == 3'd0) && (dpc == '0) && (ebreak_pc == '0) &&
                            !wfi_sleep && !illegal_dret)
    else report_mismatch("outputs in reset", 32'($sampled(cause)) | $sampled(dpc) |
                         $sampled(ebreak_pc), 32'd0);

  // -------------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------------
  function automatic int rand_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic logic coin(input int pct);
    return rand_below(100) < pct;
  endfunction

  function automatic dbg_mon_pkg::word_t rand_pc();
    dbg_mon_pkg::word_t r;
    r = $random(seed);
    r[0] = 1'b0;
    return r;
  endfunction

  // 0 ebreak, 1 c.ebreak, 2 wfi, 3 dret, 4 other 32-bit, 5 other 16-bit
  function automatic dbg_mon_pkg::word_t make_instr(input int kind);
    dbg_mon_pkg::word_t r;
    r = $random(seed);
    case (kind)
      0: return dbg_mon_pkg::ebreak_insn;
      1: return {r[31:16], dbg_mon_pkg::cebreak_insn[15:0]};
      2: return dbg_mon_pkg::wfi_insn;
      3: return dbg_mon_pkg::dret_insn;
      4: begin
        r[1:0] = 2'b11;
        if (r == dbg_mon_pkg::ebreak_insn || r == dbg_mon_pkg::wfi_insn ||
            r == dbg_mon_pkg::dret_insn) begin
          r = 32'h0000_0013;
        end
        return r;
      end
      default: return {r[31:2], 2'b01};
    endcase
  endfunction

  // One retirement; sideband stays put through the decode cycle
  task automatic retire(input dbg_mon_pkg::word_t instr, input dbg_mon_pkg::word_t pc,
                        input logic dmode, req, trig, ebm, step, irq);
    @(posedge cov_assert_if);
    wb_valid      <= 1'b1;
    wb_instr      <= instr;
    wb_pc         <= pc;
    debug_mode    <= dmode;
    debug_req     <= req;
    trigger_match <= trig;
    ebreakm       <= ebm;
    step_en       <= step;
    irq_pending   <= irq;
    @(posedge cov_assert_if);
    wb_valid <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge cov_assert_if);
      wb_valid <= 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    idle(4);
    test_count++;
    if (err_count == start) begin
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: failed with %0d errors", name, err_count - start);
    end
  endtask

  // -------------------------------------------------------------------------
  // Tests
  // -------------------------------------------------------------------------
  initial begin
    int i;
    int kind;
    int start;
    seed       = 4133;
    err_count  = 0;
    fail_tests = 0;
    test_count = 0;
    cov_assert_if = 1'b0;
    rst_n         <= 1'b0;
    wb_valid      <= 1'b0;
    wb_instr      <= '0;
    wb_pc         <= '0;
    debug_mode    <= 1'b0;
    debug_req     <= 1'b0;
    trigger_match <= 1'b0;
    ebreakm       <= 1'b0;
    step_en       <= 1'b0;
    irq_pending   <= 1'b0;
    repeat (8) @(posedge cov_assert_if);
    rst_n <= 1'b1;
    idle(2);

    start = err_count;
    for (i = 0; i < n_cause; i++) begin
      kind = rand_below(4);
      if (kind > 1) kind = kind + 2;
      retire(make_instr(kind), rand_pc(), coin(20), coin(40), coin(30), coin(50), coin(40),
             coin(20));
    end
    finish_test("cause_priority", start);

    start = err_count;
    for (i = 0; i < n_dpc; i++) begin
      kind = rand_below(4);
      if (kind > 1) kind = kind + 2;
      retire(make_instr(kind), rand_pc(), coin(25), coin(30), coin(15), coin(50), coin(30), 1'b0);
    end
    finish_test("dpc_select", start);

    start = err_count;
    for (i = 0; i < n_brk; i++) begin
      kind = (i % 2 == 0) ? rand_below(2) : 4 + rand_below(2);
      retire(make_instr(kind), rand_pc(), coin(50), coin(20), coin(20), coin(50), coin(20),
             coin(20));
    end
    finish_test("breakpoint_pc", start);

    // Sleep entry, interrupt wake, halt request wake, then blocked entries
    start = err_count;
    retire(make_instr(2), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(3);
    retire(make_instr(4), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    retire(make_instr(2), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    retire(make_instr(5), rand_pc(), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    retire(make_instr(2), rand_pc(), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    retire(make_instr(2), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    retire(make_instr(2), rand_pc(), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    retire(make_instr(2), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    retire(make_instr(4), rand_pc(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    finish_test("wfi_sleep", start);

    start = err_count;
    for (i = 0; i < n_dret; i++) begin
      retire(make_instr(3), rand_pc(), (i < 2) ? (i == 1) : coin(50), 1'b0, 1'b0, 1'b0,
             1'b0, 1'b0);
    end
    finish_test("illegal_dret", start);

    // Reset again over a busy state
    start = err_count;
    @(posedge cov_assert_if);
    rst_n <= 1'b0;
    repeat (8) @(posedge cov_assert_if);
    rst_n <= 1'b1;
    finish_test("reset", start);

    $display("tests run %0d, failed %0d, errors %0d", test_count, fail_tests, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (total_len * 10) @(posedge cov_assert_if);
    $display("watchdog: run did not finish within %0d cycles", total_len * 10);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/cause_tracker.sv
// ---------------------------------------------------------------------------
// Debug cause tracker: expected dcsr.cause by priority, WFI sleep state and
// illegal dret outside debug mode
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module cause_tracker (
  input  logic                    cov_assert_if,
  input  logic                    rst_n_i,
  retire_if.consumer              ret,
  input  logic                    debug_mode_i,
  input  logic                    debug_req_i,
  input  logic                    trigger_match_i,
  input  logic                    ebreakm_i,
  input  logic                    step_en_i,
  input  logic                    irq_pending_i,
  output logic                    capture_en_o,
  output logic                    hold_pc_o,
  output dbg_mon_pkg::dbg_cause_e cause_o,
  output logic                    wfi_sleep_o,
  output logic                    illegal_dret_o
);

  dbg_mon_pkg::dbg_cause_e cause_d;
  logic                    is_brk;
  logic                    wfi_enter;
  logic                    wfi_wake;
  logic                    dret_illegal;

  assign is_brk = (ret.op == dbg_mon_pkg::op_ebreak) || (ret.op == dbg_mon_pkg::op_cebreak);

  // -------------------------------------------------------------------------
  // Cause priority: trigger, ebreak, halt request, single step
  // -------------------------------------------------------------------------
  always_comb begin
    if (trigger_match_i) begin
      cause_d = dbg_mon_pkg::cause_trigger;
    end else if (is_brk && ebreakm_i) begin
      cause_d = dbg_mon_pkg::cause_ebreak;
    end else if (debug_req_i) begin
      cause_d = dbg_mon_pkg::cause_haltreq;
    end else if (step_en_i) begin
      cause_d = dbg_mon_pkg::cause_step;
    end else begin
      cause_d = dbg_mon_pkg::cause_none;
    end
  end

  // Retirement outside debug mode
  assign capture_en_o = ret.valid && !debug_mode_i;

  // Trigger and ebreak entries report the instruction's own PC
  assign hold_pc_o = (cause_d == dbg_mon_pkg::cause_trigger) ||
                     (cause_d == dbg_mon_pkg::cause_ebreak);

  assign wfi_enter = ret.valid && (ret.op == dbg_mon_pkg::op_wfi) &&
                     !debug_req_i && !debug_mode_i && !step_en_i;
  assign wfi_wake  = irq_pending_i || debug_req_i;

  assign dret_illegal = ret.valid && (ret.op == dbg_mon_pkg::op_dret) && !debug_mode_i;

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cause_o        <= dbg_mon_pkg::cause_none;
      wfi_sleep_o    <= 1'b0;
      illegal_dret_o <= 1'b0;
    end else begin
      // Cause holds through debug mode
      if (capture_en_o) begin
        cause_o <= cause_d;
      end
      // Wake-up wins over a new WFI
      if (wfi_wake) begin
        wfi_sleep_o <= 1'b0;
      end else if (wfi_enter) begin
        wfi_sleep_o <= 1'b1;
      end
      illegal_dret_o <= dret_illegal;
    end
  end

  // -------------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------------
  a_no_sleep_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    $rose(wfi_sleep_o) |-> !debug_mode_i
  ) else $error("wfi_sleep_o rose while in debug mode");

  // The core traps on an illegal dret, so another cannot retire right behind it
  a_dret_single_pulse: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    illegal_dret_o |=> !illegal_dret_o
  ) else $error("illegal_dret_o high in two consecutive cycles");

endmodule

`default_nettype wire

// File: design/dbg_mon_pkg.sv
// ---------------------------------------------------------------------------
// Debug-entry monitor shared definitions: widths, instruction encodings,
// the retirement opcode and the dcsr.cause values
// ---------------------------------------------------------------------------

`default_nettype none

package dbg_mon_pkg;

  // -------------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------------
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // -------------------------------------------------------------------------
  // Instruction encodings watched on the write-back stream
  // -------------------------------------------------------------------------
  localparam word_t ebreak_insn  = 32'h0010_0073;
  // Only the lower half is meaningful for c.ebreak
  localparam word_t cebreak_insn = 32'h0000_9002;
  localparam word_t wfi_insn     = 32'h1050_0073;
  localparam word_t dret_insn    = 32'h7B20_0073;

  // PC increment for a 16-bit and a 32-bit instruction
  localparam word_t ilen_compressed = 32'd2;
  localparam word_t ilen_full       = 32'd4;

  // -------------------------------------------------------------------------
  // Enums
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    op_other,
    op_ebreak,
    op_cebreak,
    op_wfi,
    op_dret
  } instr_op_e;

  // Values as encoded in dcsr.cause
  typedef enum logic [2:0] {
    cause_none    = 3'd0,
    cause_ebreak  = 3'd1,
    cause_trigger = 3'd2,
    cause_haltreq = 3'd3,
    cause_step    = 3'd4
  } dbg_cause_e;

endpackage

`default_nettype wire

// File: design/dbg_mon_top.sv
// ---------------------------------------------------------------------------
// Debug-entry monitor top level: decode, cause tracking and PC capture
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module dbg_mon_top (
  input  logic                    cov_assert_if,
  input  logic                    rst_n_i,
  // Write-back retirement
  input  logic                    wb_valid_i,
  input  dbg_mon_pkg::word_t      wb_instr_i,
  input  dbg_mon_pkg::word_t      wb_pc_i,
  // Core debug and interrupt state
  input  logic                    debug_mode_i,
  input  logic                    debug_req_i,
  input  logic                    trigger_match_i,
  input  logic                    ebreakm_i,
  input  logic                    step_en_i,
  input  logic                    irq_pending_i,
  // Expected values
  output dbg_mon_pkg::dbg_cause_e cause_o,
  output dbg_mon_pkg::word_t      dpc_o,
  output dbg_mon_pkg::word_t      ebreak_pc_o,
  output logic                    wfi_sleep_o,
  output logic                    illegal_dret_o
);

  logic capture_en;
  logic hold_pc;

  retire_if ret ();

  insn_decode i_decode (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .wb_valid_i    (wb_valid_i),
    .wb_instr_i    (wb_instr_i),
    .wb_pc_i       (wb_pc_i),
    .ret           (ret.producer)
  );

  cause_tracker i_tracker (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n_i),
    .ret             (ret.consumer),
    .debug_mode_i    (debug_mode_i),
    .debug_req_i     (debug_req_i),
    .trigger_match_i (trigger_match_i),
    .ebreakm_i       (ebreakm_i),
    .step_en_i       (step_en_i),
    .irq_pending_i   (irq_pending_i),
    .capture_en_o    (capture_en),
    .hold_pc_o       (hold_pc),
    .cause_o         (cause_o),
    .wfi_sleep_o     (wfi_sleep_o),
    .illegal_dret_o  (illegal_dret_o)
  );

  pc_capture i_capture (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .ret           (ret.consumer),
    .capture_en_i  (capture_en),
    .hold_pc_i     (hold_pc),
    .dpc_o         (dpc_o),
    .ebreak_pc_o   (ebreak_pc_o)
  );

endmodule

`default_nettype wire

// File: design/insn_decode.sv
// ---------------------------------------------------------------------------
// Retirement decode: registers each write-back retirement, classifies the
// instruction word and works out the fall-through PC
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module insn_decode (
  input  logic               cov_assert_if,
  input  logic               rst_n_i,
  input  logic               wb_valid_i,
  input  dbg_mon_pkg::word_t wb_instr_i,
  input  dbg_mon_pkg::word_t wb_pc_i,
  retire_if.producer         ret
);

  dbg_mon_pkg::instr_op_e op_d;
  logic                   is_full;

  // Low bits 2'b11 mark a 32-bit instruction
  assign is_full = (wb_instr_i[1:0] == 2'b11);

  always_comb begin
    if (wb_instr_i == dbg_mon_pkg::ebreak_insn) begin
      op_d = dbg_mon_pkg::op_ebreak;
    end else if (wb_instr_i[15:0] == dbg_mon_pkg::cebreak_insn[15:0]) begin
      op_d = dbg_mon_pkg::op_cebreak;
    end else if (wb_instr_i == dbg_mon_pkg::wfi_insn) begin
      op_d = dbg_mon_pkg::op_wfi;
    end else if (wb_instr_i == dbg_mon_pkg::dret_insn) begin
      op_d = dbg_mon_pkg::op_dret;
    end else begin
      op_d = dbg_mon_pkg::op_other;
    end
  end

  // Strobe
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret.valid <= 1'b0;
    end else begin
      ret.valid <= wb_valid_i;
    end
  end

  // Payload, only loaded with a retirement
  always_ff @(posedge cov_assert_if) begin
    if (wb_valid_i) begin
      ret.op      <= op_d;
      ret.pc      <= wb_pc_i;
      ret.next_pc <= wb_pc_i + (is_full ? dbg_mon_pkg::ilen_full
                                        : dbg_mon_pkg::ilen_compressed);
    end
  end

  // A c.ebreak classification must come from a 16-bit instruction word
  a_cebreak_is_compressed: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    ret.valid && (ret.op == dbg_mon_pkg::op_cebreak) |-> $past(wb_instr_i[1:0] != 2'b11)
  ) else $error("c.ebreak classified from a 32-bit instruction word");

endmodule

`default_nettype wire

// File: design/pc_capture.sv
// ---------------------------------------------------------------------------
// Expected dpc and breakpoint PC capture from the retirement stream
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module pc_capture (
  input  logic               cov_assert_if,
  input  logic               rst_n_i,
  retire_if.consumer         ret,
  input  logic               capture_en_i,
  input  logic               hold_pc_i,
  output dbg_mon_pkg::word_t dpc_o,
  output dbg_mon_pkg::word_t ebreak_pc_o
);

  dbg_mon_pkg::word_t dpc_d;
  logic               brk_retire;

  // Trigger and ebreak keep the instruction's PC, everything else falls through
  assign dpc_d = hold_pc_i ? ret.pc : ret.next_pc;

  assign brk_retire = ret.valid &&
                      ((ret.op == dbg_mon_pkg::op_ebreak) ||
                       (ret.op == dbg_mon_pkg::op_cebreak));

  // -------------------------------------------------------------------------
  // dpc, held through debug mode
  // -------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dpc_o <= '0;
    end else if (capture_en_i) begin
      dpc_o <= dpc_d;
    end
  end

  // -------------------------------------------------------------------------
  // Breakpoint PC, in or out of debug mode
  // -------------------------------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ebreak_pc_o <= '0;
    end else if (brk_retire) begin
      ebreak_pc_o <= ret.pc;
    end
  end

  // PCs from write-back and the increments are both even
  a_dpc_halfword_aligned: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    dpc_o[0] == 1'b0
  ) else $error("dpc_o not halfword aligned: %h", dpc_o);

endmodule

`default_nettype wire

// File: design/retire_if.sv
// ---------------------------------------------------------------------------
// One classified retirement, passed from decode to the tracker and the
// PC capture logic
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

interface retire_if;

  // Single-cycle strobe, one per retirement
  logic                   valid;
  // Fields below are meaningful only while valid is high
  dbg_mon_pkg::instr_op_e op;
  dbg_mon_pkg::word_t     pc;
  dbg_mon_pkg::word_t     next_pc;

  modport producer (
    output valid,
    output op,
    output pc,
    output next_pc
  );

  modport consumer (
    input valid,
    input op,
    input pc,
    input next_pc
  );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug-entry monitor testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module dbg_mon_tb \
  -f verilog.f \
  -o dbg_mon_sim

./obj_dir/dbg_mon_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// File: verilog.f
design/dbg_mon_pkg.sv
design/retire_if.sv
design/insn_decode.sv
design/cause_tracker.sv
design/pc_capture.sv
design/dbg_mon_top.sv
bench/dbg_mon_tb.sv
